// ==== Bender.yml ====
package:
  name: wb_subsys

sources:
  - common/wb_pkg.sv
  - common/wb_if.sv
  - rtl/wb_rr_arbiter.sv
  - interconnect/wb_interconnect_3x1.sv
  - rtl/wb_sram_target.sv
  - rtl/wb_subsys_top.sv
  - target: simulation
    files:
      - bench/tb_clkgen.sv
      - bench/tb_wb_subsys.sv

// ==== bench/tb_clkgen.sv ====
// Free-running 10 ns clock with a synchronous active-low reset
// Reset is held for 3 rising edges after time zero and after each rst_req_i pulse
`timescale 1ns/10ps

module tb_clkgen (
	input  logic rst_req_i,
	output logic clk_o,
	output logic rstn_o
);

	int rst_cnt;

	initial begin
		clk_o = 1'b0;
		forever begin
			#5 clk_o = ~clk_o;
		end
	end

	initial begin
		rstn_o = 1'b0;
		rst_cnt = 0;
	end

	// Release on the third rising edge seen with reset low
	always @(posedge clk_o) begin
		if (rst_req_i) begin
			rstn_o <= 1'b0;
			rst_cnt <= 0;
		end else if (!rstn_o) begin
			if (rst_cnt == 2) begin
				rstn_o <= 1'b1;
			end
			rst_cnt <= rst_cnt + 1;
		end
	end

endmodule

// ==== bench/tb_wb_subsys.sv ====
// Directed tests for the three-master Wishbone subsystem
// Inputs change on the rising edge, responses are sampled on the falling edge
// SRAM contents count as unknown after reset until a lane is written
`timescale 1ns/10ps

module tb_wb_subsys;

	localparam int TIMEOUT_CYCLES = 3000;
	localparam int XFER_LIMIT = 40;
	localparam logic [31:0] LFSR_SEED = 32'hb2080810;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

	logic clk;
	logic rstn;
	logic rst_req;

	// DUT inputs, indexed by master
	logic [2:0] cyc;
	logic [2:0] stb;
	logic [2:0] we;
	wb_pkg::wb_addr_t adr [3];
	wb_pkg::wb_sel_t sel [3];
	wb_pkg::wb_data_t dat_i [3];

	wire [2:0] ack_o;
	wire [2:0] err_o;
	wire [3*wb_pkg::DATA_W-1:0] dat_o;

	// Next request of each master
	logic req_we [3];
	wb_pkg::wb_addr_t req_adr [3];
	wb_pkg::wb_sel_t req_sel [3];
	wb_pkg::wb_data_t req_dat [3];

	// Responses of the last batch
	int ack_cnt [3];
	int err_cnt [3];
	int lat [3];
	wb_pkg::wb_data_t rdat [3];
	int order [$];

	// Reference memory and the lanes written since reset
	wb_pkg::wb_data_t ref_mem [wb_pkg::SRAM_WORDS];
	wb_pkg::wb_sel_t ref_known [wb_pkg::SRAM_WORDS];

	logic [31:0] lfsr_state;
	int cycles = 0;
	int errors;
	int checks;
	int n_tests;

	tb_clkgen u_clkgen (
		.rst_req_i(rst_req),
		.clk_o    (clk),
		.rstn_o   (rstn)
	);

	wb_subsys_top wb_subsys_top_inst (
		.clk     (clk),
		.rstn    (rstn),
		.m0_cyc_i(cyc[0]),
		.m0_stb_i(stb[0]),
		.m0_we_i (we[0]),
		.m0_adr_i(adr[0]),
		.m0_sel_i(sel[0]),
		.m0_dat_i(dat_i[0]),
		.m0_dat_o(dat_o[31:0]),
		.m0_ack_o(ack_o[0]),
		.m0_err_o(err_o[0]),
		.m1_cyc_i(cyc[1]),
		.m1_stb_i(stb[1]),
		.m1_we_i (we[1]),
		.m1_adr_i(adr[1]),
		.m1_sel_i(sel[1]),
		.m1_dat_i(dat_i[1]),
		.m1_dat_o(dat_o[63:32]),
		.m1_ack_o(ack_o[1]),
		.m1_err_o(err_o[1]),
		.m2_cyc_i(cyc[2]),
		.m2_stb_i(stb[2]),
		.m2_we_i (we[2]),
		.m2_adr_i(adr[2]),
		.m2_sel_i(sel[2]),
		.m2_dat_i(dat_i[2]),
		.m2_dat_o(dat_o[95:64]),
		.m2_ack_o(ack_o[2]),
		.m2_err_o(err_o[2])
	);

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Verification failed");
			$finish;
		end
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ LFSR_TAPS;
		end
		return s >> 1;
	endfunction

	// One LFSR step per bit taken
	task automatic rand_bits(input int n, output logic [31:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			val = {val[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	function automatic logic in_window(input wb_pkg::wb_addr_t a);
		return (a >= wb_pkg::SRAM_BASE) && (a <= wb_pkg::SRAM_LIMIT);
	endfunction

	function automatic int word_index(input wb_pkg::wb_addr_t a);
		return int'((a - wb_pkg::SRAM_BASE) >> 2);
	endfunction

	function automatic wb_pkg::wb_data_t lane_mask(input wb_pkg::wb_sel_t s);
		wb_pkg::wb_data_t m;
		for (int b = 0; b < wb_pkg::SEL_W; b++) begin
			m[8*b +: 8] = {8{s[b]}};
		end
		return m;
	endfunction

	task automatic model_clear();
		for (int i = 0; i < wb_pkg::SRAM_WORDS; i++) begin
			ref_mem[i] = '0;
			ref_known[i] = '0;
		end
	endtask

	task automatic model_write(input wb_pkg::wb_addr_t a, input wb_pkg::wb_sel_t s,
			input wb_pkg::wb_data_t d);
		int idx;
		wb_pkg::wb_data_t m;
		idx = word_index(a);
		m = lane_mask(s);
		ref_mem[idx] = (ref_mem[idx] & ~m) | (d & m);
		ref_known[idx] = ref_known[idx] | s;
	endtask

	task automatic report_mismatch(input string msg);
		errors++;
		$display("[FAIL] %0t %s", $time, msg);
	endtask

	task automatic report_error(input string msg);
		errors++;
		$display("Error: %s", msg);
	endtask

	task automatic wait_reset();
		@(negedge clk);
		while (rstn !== 1'b1) begin
			@(negedge clk);
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		rst_req <= 1'b1;
		@(posedge clk);
		rst_req <= 1'b0;
		wait_reset();
	endtask

	task automatic check_idle();
		checks++;
		if ((ack_o != 3'b000) || (err_o != 3'b000)) begin
			report_mismatch($sformatf("ack %b err %b after reset, expected all low", ack_o, err_o));
		end
	endtask

	task automatic set_req(input int m, input logic w, input wb_pkg::wb_addr_t a,
			input wb_pkg::wb_sel_t s, input wb_pkg::wb_data_t d);
		req_we[m] = w;
		req_adr[m] = a;
		req_sel[m] = s;
		req_dat[m] = d;
	endtask

	// Starts the masters in mask together and collects their responses
	task automatic run_xfers(input logic [2:0] mask);
		logic [2:0] pending;
		logic [2:0] seen;
		int n;
		pending = mask;
		order.delete();
		for (int m = 0; m < 3; m++) begin
			ack_cnt[m] = 0;
			err_cnt[m] = 0;
			lat[m] = -1;
			rdat[m] = '0;
		end
		@(posedge clk);
		for (int m = 0; m < 3; m++) begin
			if (mask[m]) begin
				cyc[m] <= 1'b1;
				stb[m] <= 1'b1;
				we[m] <= req_we[m];
				adr[m] <= req_adr[m];
				sel[m] <= req_sel[m];
				dat_i[m] <= req_dat[m];
			end
		end
		n = 0;
		while ((pending != 3'b000) && (n < XFER_LIMIT)) begin
			@(negedge clk);
			seen = ack_o | err_o;
			for (int m = 0; m < 3; m++) begin
				if (seen[m]) begin
					ack_cnt[m] += int'(ack_o[m]);
					err_cnt[m] += int'(err_o[m]);
					if (pending[m]) begin
						lat[m] = n;
						rdat[m] = dat_o[32*m +: 32];
						order.push_back(m);
					end
				end
			end
			pending = pending & ~seen;
			@(posedge clk);
			n++;
			// Strobe drops in the cycle after the response
			for (int m = 0; m < 3; m++) begin
				if (seen[m]) begin
					cyc[m] <= 1'b0;
					stb[m] <= 1'b0;
				end
			end
		end
		if (pending != 3'b000) begin
			report_error($sformatf("masters %b got no response in %0d cycles", pending, XFER_LIMIT));
			cyc <= 3'b000;
			stb <= 3'b000;
		end
		// Late or doubled responses
		repeat (3) begin
			@(negedge clk);
			for (int m = 0; m < 3; m++) begin
				ack_cnt[m] += int'(ack_o[m]);
				err_cnt[m] += int'(err_o[m]);
			end
		end
		for (int m = 0; m < 3; m++) begin
			checks++;
			if ((ack_cnt[m] + err_cnt[m]) != int'(mask[m])) begin
				report_mismatch($sformatf("master %0d saw %0d responses, expected %0d",
					m, ack_cnt[m] + err_cnt[m], int'(mask[m])));
			end
		end
	endtask

	// ack inside the SRAM window, err with zero data outside it
	task automatic check_resp(input int m, input wb_pkg::wb_addr_t a, input int lat_exp);
		checks++;
		if (in_window(a) && ((ack_cnt[m] != 1) || (err_cnt[m] != 0))) begin
			report_mismatch($sformatf("master %0d adr %h: %0d ack %0d err, expected one ack",
				m, a, ack_cnt[m], err_cnt[m]));
		end
		if (!in_window(a) && ((err_cnt[m] != 1) || (ack_cnt[m] != 0))) begin
			report_mismatch($sformatf("master %0d adr %h: %0d ack %0d err, expected one err",
				m, a, ack_cnt[m], err_cnt[m]));
		end
		if (!in_window(a) && (rdat[m] !== '0)) begin
			report_mismatch($sformatf("master %0d adr %h: data %h with err", m, a, rdat[m]));
		end
		if ((lat_exp >= 0) && (lat[m] != lat_exp)) begin
			report_mismatch($sformatf("master %0d adr %h: latency %0d, expected %0d",
				m, a, lat[m], lat_exp));
		end
	endtask

	task automatic check_data(input int m, input wb_pkg::wb_addr_t a);
		int idx;
		wb_pkg::wb_data_t msk;
		idx = word_index(a);
		msk = lane_mask(ref_known[idx]);
		checks++;
		if ((rdat[m] & msk) !== (ref_mem[idx] & msk)) begin
			report_mismatch($sformatf("master %0d read %h from %h, expected %h (lanes %b)",
				m, rdat[m], a, ref_mem[idx], ref_known[idx]));
		end
	endtask

	task automatic write_word(input int m, input wb_pkg::wb_addr_t a, input wb_pkg::wb_sel_t s,
			input wb_pkg::wb_data_t d, input int lat_exp);
		set_req(m, 1'b1, a, s, d);
		run_xfers(3'b001 << m);
		check_resp(m, a, lat_exp);
		if (in_window(a)) begin
			model_write(a, s, d);
		end
	endtask

	task automatic read_word(input int m, input wb_pkg::wb_addr_t a, input int lat_exp);
		set_req(m, 1'b0, a, 4'hf, '0);
		run_xfers(3'b001 << m);
		check_resp(m, a, lat_exp);
		if (in_window(a)) begin
			check_data(m, a);
		end
	endtask

	task automatic finish_test(input string name, input int err_before);
		n_tests++;
		$display("test %s finished with %0d errors", name, errors - err_before);
	endtask

	task automatic test_single_rw();
		int e0;
		e0 = errors;
		write_word(0, wb_pkg::SRAM_BASE + 32'h40, 4'hf, 32'hcafe_f00d, 3);
		read_word(0, wb_pkg::SRAM_BASE + 32'h40, 3);
		finish_test("single_rw", e0);
	endtask

	task automatic test_byte_lanes();
		int e0;
		wb_pkg::wb_sel_t lanes [4];
		wb_pkg::wb_addr_t a;
		e0 = errors;
		lanes = '{4'b0001, 4'b0110, 4'b1000, 4'b0101};
		a = wb_pkg::SRAM_BASE + 32'h84;
		write_word(1, a, 4'hf, 32'h1122_3344, 3);
		for (int i = 0; i < 4; i++) begin
			write_word(1, a, lanes[i], 32'hdead_beef ^ (i * 32'h0101_0101), 3);
			read_word(1, a, 3);
		end
		finish_test("byte_lanes", e0);
	endtask

	task automatic test_decode_err();
		int e0;
		wb_pkg::wb_addr_t bad [4];
		e0 = errors;
		// Outside addresses alias words 0 and 255 on bits 9..2
		bad = '{wb_pkg::SRAM_BASE - 32'd4, wb_pkg::SRAM_LIMIT + 32'd1, 32'h0, 32'hffff_fffc};
		write_word(2, wb_pkg::SRAM_BASE, 4'hf, 32'h0bad_0001, 3);
		write_word(2, wb_pkg::SRAM_LIMIT - 32'd3, 4'hf, 32'h0bad_00ff, 3);
		for (int i = 0; i < 4; i++) begin
			write_word(2, bad[i], 4'hf, 32'hffff_ffff, 3);
			read_word(2, bad[i], 3);
		end
		read_word(2, wb_pkg::SRAM_BASE, 3);
		read_word(2, wb_pkg::SRAM_LIMIT - 32'd3, 3);
		finish_test("decode_err", e0);
	endtask

	task automatic test_contention();
		int e0;
		wb_pkg::wb_addr_t a;
		e0 = errors;
		apply_reset();
		model_clear();
		check_idle();
		for (int r = 0; r < 2; r++) begin
			for (int m = 0; m < 3; m++) begin
				a = wb_pkg::SRAM_BASE + 32'h100 + 32'((r * 3 + m) * 4);
				set_req(m, 1'b1, a, 4'hf, 32'hc0de_0000 | 32'(r << 8) | 32'(m));
			end
			run_xfers(3'b111);
			checks++;
			if ((order.size() != 3) || (order[0] != 0) || (order[1] != 1) || (order[2] != 2)) begin
				report_mismatch($sformatf("round %0d served in order %p, expected 0 1 2", r, order));
			end
			for (int m = 0; m < 3; m++) begin
				check_resp(m, req_adr[m], (m == 0) ? 3 : -1);
				model_write(req_adr[m], req_sel[m], req_dat[m]);
			end
		end
		for (int i = 0; i < 6; i++) begin
			read_word(i % 3, wb_pkg::SRAM_BASE + 32'h100 + 32'(i * 4), 3);
		end
		finish_test("contention", e0);
	endtask

	task automatic test_indep_targets();
		int e0;
		e0 = errors;
		set_req(0, 1'b1, wb_pkg::SRAM_BASE + 32'h200, 4'hf, 32'h5a5a_1234);
		set_req(1, 1'b0, 32'h0000_2000, 4'hf, '0);
		run_xfers(3'b011);
		check_resp(0, req_adr[0], 3);
		check_resp(1, req_adr[1], 3);
		model_write(req_adr[0], req_sel[0], req_dat[0]);
		read_word(0, wb_pkg::SRAM_BASE + 32'h200, 3);
		finish_test("indep_targets", e0);
	endtask

	task automatic test_random();
		int e0;
		int m;
		logic [31:0] r;
		logic wr;
		wb_pkg::wb_addr_t a;
		wb_pkg::wb_sel_t s;
		wb_pkg::wb_data_t d;
		e0 = errors;
		for (int t = 0; t < 60; t++) begin
			rand_bits(2, r);
			m = int'(r % 3);
			rand_bits(2, r);
			// Three in four transfers hit the window
			if (r != 0) begin
				rand_bits(8, r);
				a = wb_pkg::SRAM_BASE + (r << 2);
			end else begin
				rand_bits(32, r);
				a = r;
			end
			rand_bits(1, r);
			wr = r[0];
			rand_bits(4, r);
			s = r[3:0];
			rand_bits(32, r);
			d = r;
			if (wr) begin
				write_word(m, a, s, d, 3);
			end else begin
				read_word(m, a, 3);
			end
		end
		finish_test("random", e0);
	endtask

	initial begin
		cyc = '0;
		stb = '0;
		we = '0;
		rst_req = 1'b0;
		for (int m = 0; m < 3; m++) begin
			adr[m] = '0;
			sel[m] = '0;
			dat_i[m] = '0;
			set_req(m, 1'b0, '0, '0, '0);
		end
		errors = 0;
		checks = 0;
		n_tests = 0;
		lfsr_state = LFSR_SEED;
		model_clear();
		wait_reset();
		check_idle();
		test_single_rw();
		test_byte_lanes();
		test_decode_err();
		test_contention();
		test_indep_targets();
		test_random();
		$display("Summary: %0d tests, %0d checks, %0d errors", n_tests, checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== common/wb_if.sv ====
// Wishbone classic-cycle bus, single transfers only
// No CTI, BTE, retry or stall signals
`timescale 1ns/10ps

interface wb_if;

	logic cyc;
	logic stb;
	logic we;
	wb_pkg::wb_addr_t adr;
	wb_pkg::wb_sel_t sel;
	wb_pkg::wb_data_t dat_w;
	wb_pkg::wb_data_t dat_r;
	logic ack;
	logic err;

	// Initiator side
	modport master (
		output cyc,
		output stb,
		output we,
		output adr,
		output sel,
		output dat_w,
		input  dat_r,
		input  ack,
		input  err
	);

	// Responder side
	modport slave (
		input  cyc,
		input  stb,
		input  we,
		input  adr,
		input  sel,
		input  dat_w,
		output dat_r,
		output ack,
		output err
	);

endinterface

// ==== common/wb_pkg.sv ====
// Shared widths, types and the address map of the Wishbone subsystem
// Byte addresses are 32 bits wide and the SRAM is word addressed inside its window
package wb_pkg;

	// Bus widths
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int SEL_W = DATA_W / 8;

	typedef logic [ADDR_W-1:0] wb_addr_t;
	typedef logic [DATA_W-1:0] wb_data_t;
	typedef logic [SEL_W-1:0] wb_sel_t;

	// Masters sharing the interconnect
	localparam int N_MASTERS = 3;

	typedef logic [1:0] master_id_t;

	// Target indices, one per arbiter
	typedef logic [0:0] target_id_t;

	localparam target_id_t TGT_SRAM = 1'b0;
	localparam target_id_t TGT_DERR = 1'b1;

	// SRAM window, inclusive at both ends
	localparam wb_addr_t SRAM_BASE = 32'h0000_1000;
	localparam wb_addr_t SRAM_LIMIT = 32'h0000_13FF;

	// Depth in 32-bit words, 1 KiB in total
	localparam int SRAM_WORDS = 256;

endpackage

// ==== compile.f ====
common/wb_pkg.sv
common/wb_if.sv
rtl/wb_rr_arbiter.sv
interconnect/wb_interconnect_3x1.sv
rtl/wb_sram_target.sv
rtl/wb_subsys_top.sv
bench/tb_clkgen.sv
bench/tb_wb_subsys.sv

// ==== interconnect/wb_interconnect_3x1.sv ====
// Three masters to one SRAM target, with an internal decode-fail responder
// Each target has its own arbiter, so SRAM and error transfers overlap
// Masters must hold their request until ack or err, classic cycles only
`timescale 1ns/10ps

module wb_interconnect_3x1 (
	input  logic clk,
	input  logic rstn,
	wb_if.slave  m0_i,
	wb_if.slave  m1_i,
	wb_if.slave  m2_i,
	wb_if.master s0_o
);

	localparam int N_TGT = 2;

	typedef enum logic {
		ST_IDLE,
		ST_WAIT
	} mst_state_e;

	// Decode-fail responder bus
	wb_if derr_bus ();

	// Master side, flattened for indexing
	logic [wb_pkg::N_MASTERS-1:0] m_cyc;
	logic [wb_pkg::N_MASTERS-1:0] m_stb;
	logic [wb_pkg::N_MASTERS-1:0] m_we;
	logic [wb_pkg::N_MASTERS-1:0] m_ack;
	logic [wb_pkg::N_MASTERS-1:0] m_err;
	logic [wb_pkg::N_MASTERS-1:0] m_served;
	wb_pkg::wb_addr_t m_adr [wb_pkg::N_MASTERS];
	wb_pkg::wb_sel_t m_sel [wb_pkg::N_MASTERS];
	wb_pkg::wb_data_t m_dat_w [wb_pkg::N_MASTERS];
	wb_pkg::wb_data_t m_dat_r [wb_pkg::N_MASTERS];

	// Per-master tracking
	mst_state_e state [wb_pkg::N_MASTERS];
	wb_pkg::target_id_t tgt [wb_pkg::N_MASTERS];

	// Target side, index 0 is the SRAM and 1 the error responder
	logic [wb_pkg::N_MASTERS-1:0] t_req [N_TGT];
	logic [N_TGT-1:0] t_gnt;
	wb_pkg::master_id_t t_gnt_id [N_TGT];
	logic t_cyc [N_TGT];
	logic t_stb [N_TGT];
	logic t_we [N_TGT];
	wb_pkg::wb_addr_t t_adr [N_TGT];
	wb_pkg::wb_sel_t t_sel [N_TGT];
	wb_pkg::wb_data_t t_dat_w [N_TGT];
	wb_pkg::wb_data_t t_dat_r [N_TGT];
	logic t_ack [N_TGT];
	logic t_err [N_TGT];

	logic derr_err;

	function automatic wb_pkg::target_id_t decode(input wb_pkg::wb_addr_t adr);
		wb_pkg::target_id_t id;
		if ((adr >= wb_pkg::SRAM_BASE) && (adr <= wb_pkg::SRAM_LIMIT)) begin
			id = wb_pkg::TGT_SRAM;
		end else begin
			id = wb_pkg::TGT_DERR;
		end
		return id;
	endfunction

	assign m_cyc = {m2_i.cyc, m1_i.cyc, m0_i.cyc};
	assign m_stb = {m2_i.stb, m1_i.stb, m0_i.stb};
	assign m_we = {m2_i.we, m1_i.we, m0_i.we};
	assign m_adr = '{m0_i.adr, m1_i.adr, m2_i.adr};
	assign m_sel = '{m0_i.sel, m1_i.sel, m2_i.sel};
	assign m_dat_w = '{m0_i.dat_w, m1_i.dat_w, m2_i.dat_w};

	assign m0_i.ack = m_ack[0];
	assign m1_i.ack = m_ack[1];
	assign m2_i.ack = m_ack[2];
	assign m0_i.err = m_err[0];
	assign m1_i.err = m_err[1];
	assign m2_i.err = m_err[2];
	assign m0_i.dat_r = m_dat_r[0];
	assign m1_i.dat_r = m_dat_r[1];
	assign m2_i.dat_r = m_dat_r[2];

	for (genvar i = 0; i < wb_pkg::N_MASTERS; i++) begin : g_mst
		// Latch the addressed target on the first sampled strobe
		always_ff @(posedge clk) begin
			if (!rstn) begin
				state[i] <= ST_IDLE;
				tgt[i] <= wb_pkg::TGT_SRAM;
			end else begin
				case (state[i])
					ST_IDLE: begin
						if (m_cyc[i] && m_stb[i]) begin
							state[i] <= ST_WAIT;
							tgt[i] <= decode(m_adr[i]);
						end
					end
					ST_WAIT: begin
						if (m_ack[i] || m_err[i]) begin
							state[i] <= ST_IDLE;
							tgt[i] <= wb_pkg::TGT_SRAM;
						end
					end
					default: state[i] <= ST_IDLE;
				endcase
			end
		end

		// Responses only reach the master that owns the target
		assign m_served[i] = (state[i] == ST_WAIT) && t_gnt[tgt[i]] &&
			(t_gnt_id[tgt[i]] == wb_pkg::master_id_t'(i));
		assign m_ack[i] = m_served[i] && t_ack[tgt[i]];
		assign m_err[i] = m_served[i] && t_err[tgt[i]];
		assign m_dat_r[i] = m_served[i] ? t_dat_r[tgt[i]] : '0;

		for (genvar t = 0; t < N_TGT; t++) begin : g_req
			assign t_req[t][i] = (state[i] == ST_WAIT) &&
				(tgt[i] == wb_pkg::target_id_t'(t));
		end
	end

	for (genvar t = 0; t < N_TGT; t++) begin : g_tgt
		wb_rr_arbiter #(
			.N_REQ(wb_pkg::N_MASTERS)
		) u_arb (
			.clk     (clk),
			.rstn    (rstn),
			.req_i   (t_req[t]),
			.gnt_o   (t_gnt[t]),
			.gnt_id_o(t_gnt_id[t])
		);

		// Request mux, idle bus when nobody holds the grant
		assign t_cyc[t] = t_gnt[t] ? m_cyc[t_gnt_id[t]] : 1'b0;
		assign t_stb[t] = t_gnt[t] ? m_stb[t_gnt_id[t]] : 1'b0;
		assign t_we[t] = t_gnt[t] ? m_we[t_gnt_id[t]] : 1'b0;
		assign t_adr[t] = t_gnt[t] ? m_adr[t_gnt_id[t]] : '0;
		assign t_sel[t] = t_gnt[t] ? m_sel[t_gnt_id[t]] : '0;
		assign t_dat_w[t] = t_gnt[t] ? m_dat_w[t_gnt_id[t]] : '0;
	end

	assign s0_o.cyc = t_cyc[wb_pkg::TGT_SRAM];
	assign s0_o.stb = t_stb[wb_pkg::TGT_SRAM];
	assign s0_o.we = t_we[wb_pkg::TGT_SRAM];
	assign s0_o.adr = t_adr[wb_pkg::TGT_SRAM];
	assign s0_o.sel = t_sel[wb_pkg::TGT_SRAM];
	assign s0_o.dat_w = t_dat_w[wb_pkg::TGT_SRAM];
	assign t_dat_r[wb_pkg::TGT_SRAM] = s0_o.dat_r;
	assign t_ack[wb_pkg::TGT_SRAM] = s0_o.ack;
	assign t_err[wb_pkg::TGT_SRAM] = s0_o.err;

	assign derr_bus.cyc = t_cyc[wb_pkg::TGT_DERR];
	assign derr_bus.stb = t_stb[wb_pkg::TGT_DERR];
	assign derr_bus.we = t_we[wb_pkg::TGT_DERR];
	assign derr_bus.adr = t_adr[wb_pkg::TGT_DERR];
	assign derr_bus.sel = t_sel[wb_pkg::TGT_DERR];
	assign derr_bus.dat_w = t_dat_w[wb_pkg::TGT_DERR];
	assign t_dat_r[wb_pkg::TGT_DERR] = derr_bus.dat_r;
	assign t_ack[wb_pkg::TGT_DERR] = derr_bus.ack;
	assign t_err[wb_pkg::TGT_DERR] = derr_bus.err;

	// Decode-fail responder, one err pulse per strobe
	always_ff @(posedge clk) begin
		if (!rstn) begin
			derr_err <= 1'b0;
		end else begin
			derr_err <= derr_bus.cyc && derr_bus.stb && !derr_err;
		end
	end

	assign derr_bus.err = derr_err;
	assign derr_bus.ack = 1'b0;
	assign derr_bus.dat_r = '0;

	// ack comes from the SRAM and err from the responder, never both at once
	a_ack_err_excl: assert property (
		@(posedge clk) disable iff (!rstn)
		(m_ack & m_err) == '0
	);

endmodule

// ==== rtl/wb_rr_arbiter.sv ====
// Round-robin arbiter, the grant is held until the granted request drops
// One idle cycle always separates two grants
`timescale 1ns/10ps

module wb_rr_arbiter #(
	parameter int N_REQ = 2
) (
	input  logic                                        clk,
	input  logic                                        rstn,
	input  logic [N_REQ-1:0]                            req_i,
	output logic                                        gnt_o,
	output logic [((N_REQ > 1) ? $clog2(N_REQ) : 1)-1:0] gnt_id_o
);

	localparam int ID_W = (N_REQ > 1) ? $clog2(N_REQ) : 1;

	// Set once the first grant has been given
	logic last_vld;

	logic nxt_vld;
	logic [ID_W-1:0] nxt_id;
	logic found_hi;
	logic [ID_W-1:0] id_hi;
	logic [ID_W-1:0] id_lo;

	// Lowest request above the last grant, else the lowest request overall
	always_comb begin
		found_hi = 1'b0;
		nxt_vld = 1'b0;
		id_hi = '0;
		id_lo = '0;
		for (int i = N_REQ - 1; i >= 0; i--) begin
			if (req_i[i]) begin
				nxt_vld = 1'b1;
				id_lo = ID_W'(i);
				if (last_vld && (i > int'(gnt_id_o))) begin
					found_hi = 1'b1;
					id_hi = ID_W'(i);
				end
			end
		end
		nxt_id = found_hi ? id_hi : id_lo;
	end

	// gnt_id_o keeps the last winner after release and serves as the pointer
	always_ff @(posedge clk) begin
		if (!rstn) begin
			gnt_o <= 1'b0;
			gnt_id_o <= '0;
			last_vld <= 1'b0;
		end else if (!gnt_o) begin
			if (nxt_vld) begin
				gnt_o <= 1'b1;
				gnt_id_o <= nxt_id;
				last_vld <= 1'b1;
			end
		end else if (!req_i[gnt_id_o]) begin
			gnt_o <= 1'b0;
		end
	end

	a_gnt_id_range: assert property (
		@(posedge clk) disable iff (!rstn)
		int'(gnt_id_o) < N_REQ
	);

	// A live request keeps its grant
	a_gnt_hold: assert property (
		@(posedge clk) disable iff (!rstn)
		gnt_o && req_i[gnt_id_o] |=> gnt_o
	);

endmodule

// ==== rtl/wb_sram_target.sv ====
// Word SRAM on a Wishbone slave port, contents undefined after reset
// Only address bits 9..2 are used, the window check is done upstream
`timescale 1ns/10ps

module wb_sram_target (
	input  logic clk,
	input  logic rstn,
	wb_if.slave  bus_i
);

	localparam int IDX_W = $clog2(wb_pkg::SRAM_WORDS);

	wb_pkg::wb_data_t mem [wb_pkg::SRAM_WORDS];

	logic [IDX_W-1:0] idx;
	logic req_new;
	logic ack_q;
	wb_pkg::wb_data_t rdata_q;

	// Word index from the byte address
	assign idx = bus_i.adr[IDX_W+1:2];

	// A strobe still high during its own ack is not a new request
	assign req_new = bus_i.cyc && bus_i.stb && !ack_q;

	// Storage and read data
	always_ff @(posedge clk) begin
		if (req_new) begin
			if (bus_i.we) begin
				for (int b = 0; b < wb_pkg::SEL_W; b++) begin
					if (bus_i.sel[b]) begin
						mem[idx][8*b +: 8] <= bus_i.dat_w[8*b +: 8];
					end
				end
			end else begin
				rdata_q <= mem[idx];
			end
		end
	end

	// Single-beat ack
	always_ff @(posedge clk) begin
		if (!rstn) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req_new;
		end
	end

	assign bus_i.ack = ack_q;
	assign bus_i.err = 1'b0;
	assign bus_i.dat_r = rdata_q;

	a_ack_after_stb: assert property (
		@(posedge clk) disable iff (!rstn)
		bus_i.ack |-> $past(bus_i.stb)
	);

endmodule

// ==== rtl/wb_subsys_top.sv ====
// Three Wishbone masters sharing one 1 KiB SRAM at 0x1000..0x13FF
// Accesses outside the window end with err, uncontended latency is 3 cycles
`timescale 1ns/10ps

module wb_subsys_top (
	input  logic              clk,
	input  logic              rstn,
	// Master 0
	input  logic              m0_cyc_i,
	input  logic              m0_stb_i,
	input  logic              m0_we_i,
	input  wb_pkg::wb_addr_t  m0_adr_i,
	input  wb_pkg::wb_sel_t   m0_sel_i,
	input  wb_pkg::wb_data_t  m0_dat_i,
	output wb_pkg::wb_data_t  m0_dat_o,
	output logic              m0_ack_o,
	output logic              m0_err_o,
	// Master 1
	input  logic              m1_cyc_i,
	input  logic              m1_stb_i,
	input  logic              m1_we_i,
	input  wb_pkg::wb_addr_t  m1_adr_i,
	input  wb_pkg::wb_sel_t   m1_sel_i,
	input  wb_pkg::wb_data_t  m1_dat_i,
	output wb_pkg::wb_data_t  m1_dat_o,
	output logic              m1_ack_o,
	output logic              m1_err_o,
	// Master 2
	input  logic              m2_cyc_i,
	input  logic              m2_stb_i,
	input  logic              m2_we_i,
	input  wb_pkg::wb_addr_t  m2_adr_i,
	input  wb_pkg::wb_sel_t   m2_sel_i,
	input  wb_pkg::wb_data_t  m2_dat_i,
	output wb_pkg::wb_data_t  m2_dat_o,
	output logic              m2_ack_o,
	output logic              m2_err_o
);

	wb_if m0 ();
	wb_if m1 ();
	wb_if m2 ();
	wb_if sram_bus ();

	assign m0.cyc = m0_cyc_i;
	assign m0.stb = m0_stb_i;
	assign m0.we = m0_we_i;
	assign m0.adr = m0_adr_i;
	assign m0.sel = m0_sel_i;
	assign m0.dat_w = m0_dat_i;
	assign m0_dat_o = m0.dat_r;
	assign m0_ack_o = m0.ack;
	assign m0_err_o = m0.err;

	assign m1.cyc = m1_cyc_i;
	assign m1.stb = m1_stb_i;
	assign m1.we = m1_we_i;
	assign m1.adr = m1_adr_i;
	assign m1.sel = m1_sel_i;
	assign m1.dat_w = m1_dat_i;
	assign m1_dat_o = m1.dat_r;
	assign m1_ack_o = m1.ack;
	assign m1_err_o = m1.err;

	assign m2.cyc = m2_cyc_i;
	assign m2.stb = m2_stb_i;
	assign m2.we = m2_we_i;
	assign m2.adr = m2_adr_i;
	assign m2.sel = m2_sel_i;
	assign m2.dat_w = m2_dat_i;
	assign m2_dat_o = m2.dat_r;
	assign m2_ack_o = m2.ack;
	assign m2_err_o = m2.err;

	wb_interconnect_3x1 u_xbar (
		.clk (clk),
		.rstn(rstn),
		.m0_i(m0.slave),
		.m1_i(m1.slave),
		.m2_i(m2.slave),
		.s0_o(sram_bus.master)
	);

	wb_sram_target u_sram (
		.clk  (clk),
		.rstn (rstn),
		.bus_i(sram_bus.slave)
	);

endmodule
